//--- verilog/hazard_pkg.sv
// Shared widths, opcode constants, stage count and forward-source codes for the hazard unit
package hazard_pkg;

	// Field widths
	typedef logic [2:0]  reg_idx_t;	// Register number, eight registers
	typedef logic [4:0]  opcode_t;	// Major opcode
	typedef logic [15:0] instr_t;	// Instruction word
	typedef logic [1:0]  fwd_sel_t;	// Forward source select

	// Forward source codes, one above the slot index they name
	localparam fwd_sel_t FWD_NONE = 2'd0;	// Register file value
	localparam fwd_sel_t FWD_EX   = 2'd1;	// EX stage result
	localparam fwd_sel_t FWD_MEM  = 2'd2;	// MEM stage result
	localparam fwd_sel_t FWD_WB   = 2'd3;	// Register file bypass from WB

	// Producer slots: EX, MEM, WB
	localparam int NUM_STAGES = 3;

	// Special and control opcodes
	localparam opcode_t OP_HALT = 5'b00000;
	localparam opcode_t OP_NOP  = 5'b00001;
	localparam opcode_t OP_SIIC = 5'b00010;
	localparam opcode_t OP_RTI  = 5'b00011;

	// Jumps
	localparam opcode_t OP_J    = 5'b00100;
	localparam opcode_t OP_JR   = 5'b00101;	// Resolved in decode
	localparam opcode_t OP_JAL  = 5'b00110;
	localparam opcode_t OP_JALR = 5'b00111;	// Resolved in decode

	// Immediate loads and memory access
	localparam opcode_t OP_LBI = 5'b11000;	// Writes rs
	localparam opcode_t OP_ST  = 5'b10000;
	localparam opcode_t OP_STU = 5'b10011;	// Store with rs update
	localparam opcode_t OP_LD  = 5'b10001;

	// R-format groups
	localparam opcode_t OP_ALU_R   = 5'b11011;	// ADD, SUB, XOR, ANDN
	localparam opcode_t OP_SHIFT_R = 5'b11010;	// ROL, SLL, ROR, SRL

	// Three-bit opcode prefixes covering a group of four
	localparam logic [2:0] BRANCH_PREFIX = 3'b011;	// BEQZ, BNEZ, BLTZ, BGEZ
	localparam logic [2:0] SET_PREFIX    = 3'b111;	// SEQ, SLT, SLE, SCO

	// Link register written by JAL and JALR
	localparam reg_idx_t LINK_REG = 3'd7;

endpackage

//--- verilog/instr_decode.sv
// Decode-stage classifier: splits the word into operand and destination fields, flags its class
module instr_decode (
	input  hazard_pkg::instr_t   instr,
	input  logic                 instr_valid,
	output hazard_pkg::reg_idx_t rs,
	output hazard_pkg::reg_idx_t rt,
	output hazard_pkg::reg_idx_t dest,
	output logic                 rs_used,
	output logic                 rt_used,
	output logic                 reg_write,
	output logic                 mem_read,
	output logic                 is_branch,
	output logic                 is_jalr
);
	import hazard_pkg::*;

	opcode_t op;
	logic    r_format;	// Three-register format
	logic    cond_branch;	// BEQZ group
	logic    writes_reg;
	logic    reads_rs;
	logic    reads_rt;
	logic    decode_jump;	// JR or JALR

	assign op = instr[15:11];

	// Operand fields sit at fixed positions in every format
	assign rs = instr[10:8];
	assign rt = instr[7:5];

	assign cond_branch = (op[4:2] == BRANCH_PREFIX);
	assign decode_jump = (op == OP_JR) | (op == OP_JALR);
	assign r_format    = (op == OP_ALU_R) | (op == OP_SHIFT_R) | (op[4:2] == SET_PREFIX);

	always_comb begin
		case (op)
			OP_ST, OP_J, OP_JR, OP_HALT, OP_NOP, OP_SIIC, OP_RTI: begin
				writes_reg = 1'b0;
			end
			default: begin
				writes_reg = ~cond_branch;	// Branches write nothing
			end
		endcase
	end

	always_comb begin
		case (op)
			OP_LBI, OP_J, OP_JAL, OP_HALT, OP_NOP, OP_SIIC, OP_RTI: begin
				reads_rs = 1'b0;
			end
			default: begin
				reads_rs = 1'b1;
			end
		endcase
	end

	// Stores read the data register through rt
	assign reads_rt = (op == OP_ST) | (op == OP_STU) | r_format;

	// Destination field depends on the format
	always_comb begin
		if (r_format) begin
			dest = instr[4:2];
		end else if ((op == OP_LBI) || (op == OP_STU)) begin
			dest = rs;	// Rs is both source and target
		end else if ((op == OP_JAL) || (op == OP_JALR)) begin
			dest = LINK_REG;
		end else begin
			dest = instr[7:5];	// I-format arithmetic and LD
		end
	end

	// An invalid word looks like a NOP downstream
	assign rs_used   = instr_valid & reads_rs;
	assign rt_used   = instr_valid & reads_rt;
	assign reg_write = instr_valid & writes_reg;
	assign mem_read  = instr_valid & (op == OP_LD);
	assign is_branch = instr_valid & (cond_branch | decode_jump);
	assign is_jalr   = instr_valid & (op == OP_JALR);

endmodule

//--- verilog/dest_slot.sv
// One pipeline stage's producer record; compares its destination against the decode operands
module dest_slot (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 load_bubble,
	input  hazard_pkg::reg_idx_t in_dest,
	input  logic                 in_reg_write,
	input  logic                 in_mem_read,
	input  hazard_pkg::reg_idx_t rs,
	input  hazard_pkg::reg_idx_t rt,
	output hazard_pkg::reg_idx_t out_dest,
	output logic                 out_reg_write,
	output logic                 out_mem_read,
	output logic                 rs_hit,
	output logic                 rt_hit
);
	import hazard_pkg::*;

	reg_idx_t dest_q;
	logic     reg_write_q;
	logic     mem_read_q;

	// Class bits clear to a bubble on reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			reg_write_q <= 1'b0;
			mem_read_q  <= 1'b0;
		end else if (load_bubble) begin
			reg_write_q <= 1'b0;	// Bubble writes nothing
			mem_read_q  <= 1'b0;
		end else begin
			reg_write_q <= in_reg_write;
			mem_read_q  <= in_mem_read;
		end
	end

	// Destination of the stored record
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dest_q <= '0;
		end else begin
			dest_q <= in_dest;
		end
	end

	assign out_dest      = dest_q;
	assign out_reg_write = reg_write_q;
	assign out_mem_read  = mem_read_q;

	assign rs_hit = reg_write_q & (dest_q == rs);
	assign rt_hit = reg_write_q & (dest_q == rt);

endmodule

//--- verilog/hazard_detection.sv
// Hazard detector: turns slot matches and decode class into stall, forward selects and XD bypass
module hazard_detection (
	input  logic                                rs_used,
	input  logic                                rt_used,
	input  logic                                is_branch,
	input  logic                                is_jalr,
	input  logic [hazard_pkg::NUM_STAGES-1:0]   rs_hit,
	input  logic [hazard_pkg::NUM_STAGES-1:0]   rt_hit,
	input  logic [hazard_pkg::NUM_STAGES-1:0]   slot_mem_read,
	output logic                                stall,
	output logic                                xd_fwd,
	output hazard_pkg::fwd_sel_t                fwd_rs_sel,
	output hazard_pkg::fwd_sel_t                fwd_rt_sel
);
	import hazard_pkg::*;

	localparam int EX  = 0;	// Slot indices
	localparam int MEM = 1;

	logic     rs_live_hit_ex;	// Used rs produced in EX
	logic     rt_live_hit_ex;
	logic     load_use_stall;
	logic     branch_rs;	// Decode-resolved control reading rs
	logic     jalr_pass;
	logic     branch_ex_stall;
	logic     branch_mem_stall;
	logic     mem_producer;	// Nearest rs producer sits in MEM
	fwd_sel_t rs_nearest;
	fwd_sel_t rt_nearest;

	// Nearest producer wins; slot k maps onto code k+1
	function automatic fwd_sel_t pick_source(
		input logic                  used,
		input logic [NUM_STAGES-1:0] hit
	);
		fwd_sel_t sel;
		sel = FWD_NONE;
		if (used) begin
			// Walk from WB down so EX overrides
			for (int k = NUM_STAGES - 1; k >= 0; k--) begin
				if (hit[k]) begin
					sel = fwd_sel_t'(k + 1);
				end
			end
		end
		return sel;
	endfunction

	// Load data is not ready until it leaves MEM
	assign rs_live_hit_ex = rs_used & rs_hit[EX];
	assign rt_live_hit_ex = rt_used & rt_hit[EX];
	assign load_use_stall = slot_mem_read[EX] & (rs_live_hit_ex | rt_live_hit_ex);

	assign branch_rs = is_branch & rs_used;

	// JALR takes its target after EX, so an ALU result in EX can still feed it
	assign jalr_pass = is_jalr & rs_hit[EX] & ~slot_mem_read[EX];

	assign branch_ex_stall = branch_rs & rs_hit[EX] & ~jalr_pass;

	// Producer already in MEM: a load still needs one more cycle
	assign mem_producer     = ~rs_hit[EX] & rs_hit[MEM];
	assign branch_mem_stall = branch_rs & mem_producer & slot_mem_read[MEM];

	// ALU result in MEM goes straight back to the decode comparator
	assign xd_fwd = branch_rs & mem_producer & ~slot_mem_read[MEM];

	assign stall = load_use_stall | branch_ex_stall | branch_mem_stall;

	assign rs_nearest = pick_source(rs_used, rs_hit);
	assign rt_nearest = pick_source(rt_used, rt_hit);

	// Stalled word is replayed next cycle, no select this one
	assign fwd_rs_sel = stall ? FWD_NONE : rs_nearest;
	assign fwd_rt_sel = stall ? FWD_NONE : rt_nearest;

endmodule

//--- verilog/hazard_unit_top.sv
// Top of the decode hazard unit: decoder, EX/MEM/WB producer slot chain and the detector
module hazard_unit_top (
	input  logic                 clk,
	input  logic                 arst_n,
	input  hazard_pkg::instr_t   instr,
	input  logic                 instr_valid,
	output logic                 stall,
	output logic                 xd_fwd,
	output hazard_pkg::fwd_sel_t fwd_rs_sel,
	output hazard_pkg::fwd_sel_t fwd_rt_sel
);
	import hazard_pkg::*;

	reg_idx_t rs;
	reg_idx_t rt;
	logic     rs_used;
	logic     rt_used;
	logic     is_branch;
	logic     is_jalr;

	// Chain links; entry 0 comes from decode, entry k+1 from slot k
	reg_idx_t              chain_dest [NUM_STAGES+1];
	logic [NUM_STAGES:0]   chain_reg_write;
	logic [NUM_STAGES:0]   chain_mem_read;
	logic [NUM_STAGES-1:0] slot_bubble;
	logic [NUM_STAGES-1:0] rs_hit;
	logic [NUM_STAGES-1:0] rt_hit;

	instr_decode instr_decode_i (
		.instr       (instr),
		.instr_valid (instr_valid),
		.rs          (rs),
		.rt          (rt),
		.dest        (chain_dest[0]),
		.rs_used     (rs_used),
		.rt_used     (rt_used),
		.reg_write   (chain_reg_write[0]),
		.mem_read    (chain_mem_read[0]),
		.is_branch   (is_branch),
		.is_jalr     (is_jalr)
	);

	// Only EX takes a bubble; later slots just shift
	assign slot_bubble = {{(NUM_STAGES-1){1'b0}}, stall};

	for (genvar k = 0; k < NUM_STAGES; k++) begin : g_slot
		dest_slot dest_slot_i (
			.clk           (clk),
			.arst_n        (arst_n),
			.load_bubble   (slot_bubble[k]),
			.in_dest       (chain_dest[k]),
			.in_reg_write  (chain_reg_write[k]),
			.in_mem_read   (chain_mem_read[k]),
			.rs            (rs),
			.rt            (rt),
			.out_dest      (chain_dest[k+1]),
			.out_reg_write (chain_reg_write[k+1]),
			.out_mem_read  (chain_mem_read[k+1]),
			.rs_hit        (rs_hit[k]),
			.rt_hit        (rt_hit[k])
		);
	end

	hazard_detection hazard_detection_i (
		.rs_used       (rs_used),
		.rt_used       (rt_used),
		.is_branch     (is_branch),
		.is_jalr       (is_jalr),
		.rs_hit        (rs_hit),
		.rt_hit        (rt_hit),
		.slot_mem_read (chain_mem_read[NUM_STAGES:1]),	// Stored load flag per slot
		.stall         (stall),
		.xd_fwd        (xd_fwd),
		.fwd_rs_sel    (fwd_rs_sel),
		.fwd_rt_sel    (fwd_rt_sel)
	);

endmodule

//--- sim/hazard_unit_chk.sv
// Concurrent assertions on the hazard unit outputs; bound into hazard_unit_top for simulation
module hazard_unit_chk (
	input logic                 clk,
	input logic                 arst_n,
	input logic                 stall,
	input logic                 xd_fwd,
	input hazard_pkg::fwd_sel_t fwd_rs_sel,
	input hazard_pkg::fwd_sel_t fwd_rt_sel
);
	import hazard_pkg::*;

	int fail_count = 0;	// Failed assertion count

	// A stalled word is replayed, so it takes no forward path
	stall_no_select: assert property (@(posedge clk) disable iff (!arst_n)
		stall |-> ((fwd_rs_sel == FWD_NONE) && (fwd_rt_sel == FWD_NONE)))
	else begin
		$error("forward select active while the decode stage is stalled");
		fail_count++;
	end

	// XD bypass only serves a branch that proceeds
	xd_not_stalled: assert property (@(posedge clk) disable iff (!arst_n)
		!(xd_fwd && stall))
	else begin
		$error("branch bypass raised together with stall");
		fail_count++;
	end

	// All slots are bubbles right after reset
	no_stall_after_reset: assert property (@(posedge clk)
		$rose(arst_n) |-> !stall)
	else begin
		$error("stall raised in the first cycle after reset");
		fail_count++;
	end

	// Worst case is a load feeding a branch
	stall_max_two: assert property (@(posedge clk) disable iff (!arst_n)
		!(stall && $past(stall) && $past(stall, 2)))
	else begin
		$error("stall held for more than two cycles");
		fail_count++;
	end

endmodule

bind hazard_unit_top hazard_unit_chk hazard_unit_chk_i (
	.clk        (clk),
	.arst_n     (arst_n),
	.stall      (stall),
	.xd_fwd     (xd_fwd),
	.fwd_rs_sel (fwd_rs_sel),
	.fwd_rt_sel (fwd_rt_sel)
);

//--- sim/hazard_unit_tb.sv
// Testbench for the decode hazard unit: applies an instruction table and checks it against a model
module hazard_unit_tb;
	import hazard_pkg::*;

	logic     clk;
	logic     arst_n;
	instr_t   instr;
	logic     instr_valid;
	logic     stall;
	logic     xd_fwd;
	fwd_sel_t fwd_rs_sel;
	fwd_sel_t fwd_rt_sel;

	// Table columns: word, valid, stall cycles, rs select, rt select, xd_fwd once issued
	instr_t   tab_word [$];
	logic     tab_valid [$];
	int       tab_stalls [$];
	fwd_sel_t tab_rs [$];
	fwd_sel_t tab_rt [$];
	logic     tab_xd [$];

	// Reference producer records, index 0 is EX
	reg_idx_t slot_dest [NUM_STAGES];
	logic     slot_wr [NUM_STAGES];
	logic     slot_ld [NUM_STAGES];

	reg_idx_t cur_dest;	// Record of the word in decode
	logic     cur_wr;
	logic     cur_ld;
	logic     exp_stall;

	hazard_unit_top hazard_unit_top_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr       (instr),
		.instr_valid (instr_valid),
		.stall       (stall),
		.xd_fwd      (xd_fwd),
		.fwd_rs_sel  (fwd_rs_sel),
		.fwd_rt_sel  (fwd_rt_sel)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic check_level(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			report_failure($sformatf("mismatch at %0t: %s is %b, expected %b",
				$time, name, actual, expected));
		end
	endtask

	task automatic check_sel(input string name, input fwd_sel_t actual, input fwd_sel_t expected);
		if (actual !== expected) begin
			report_failure($sformatf("mismatch at %0t: %s is %0d, expected %0d",
				$time, name, actual, expected));
		end
	endtask

	task automatic expect_stalls(input string name, input int actual, input int expected);
		if (actual != expected) begin
			report_failure($sformatf("mismatch at %0t: %s held %0d cycles, expected %0d",
				$time, name, actual, expected));
		end
	endtask

	function automatic instr_t three_reg(input opcode_t op, input reg_idx_t a, input reg_idx_t b,
		input reg_idx_t c);
		return {op, a, b, c, 2'b00};
	endfunction

	function automatic instr_t reg_imm5(input opcode_t op, input reg_idx_t a, input reg_idx_t b,
		input logic [4:0] imm);
		return {op, a, b, imm};
	endfunction

	function automatic instr_t reg_imm8(input opcode_t op, input reg_idx_t a,
		input logic [7:0] imm);
		return {op, a, imm};
	endfunction

	task automatic add_entry(input instr_t word, input logic valid, input int stalls,
		input fwd_sel_t rs_sel, input fwd_sel_t rt_sel, input logic xd);
		tab_word.push_back(word);
		tab_valid.push_back(valid);
		tab_stalls.push_back(stalls);
		tab_rs.push_back(rs_sel);
		tab_rt.push_back(rt_sel);
		tab_xd.push_back(xd);
	endtask

	// Classifies a word from the ISA field rules
	task automatic decode_word(
		input  instr_t   word,
		input  logic     valid,
		output reg_idx_t rs,
		output reg_idx_t rt,
		output reg_idx_t dest,
		output logic     rs_used,
		output logic     rt_used,
		output logic     wr,
		output logic     ld,
		output logic     br,
		output logic     jalr
	);
		opcode_t op;
		logic    r_fmt;
		op = word[15:11];
		rs = word[10:8];
		rt = word[7:5];
		r_fmt = (op == OP_ALU_R) || (op == OP_SHIFT_R) || (op[4:2] == SET_PREFIX);
		dest = r_fmt ? word[4:2] : word[7:5];
		rs_used = 1'b1;	// I-format arithmetic as the base case
		rt_used = r_fmt;
		wr = 1'b1;
		ld = 1'b0;
		br = (op[4:2] == BRANCH_PREFIX);
		jalr = 1'b0;
		if (br) begin
			wr = 1'b0;
		end
		case (op)
			OP_HALT, OP_NOP, OP_SIIC, OP_RTI, OP_J: begin
				wr = 1'b0;
				rs_used = 1'b0;
			end
			OP_JAL: begin
				rs_used = 1'b0;
				dest = LINK_REG;
			end
			OP_JR: begin
				wr = 1'b0;
				br = 1'b1;
			end
			OP_JALR: begin
				dest = LINK_REG;
				br = 1'b1;
				jalr = 1'b1;
			end
			OP_LBI: begin
				rs_used = 1'b0;
				dest = rs;
			end
			OP_ST: begin
				wr = 1'b0;
				rt_used = 1'b1;
			end
			OP_STU: begin
				dest = rs;
				rt_used = 1'b1;
			end
			OP_LD: ld = 1'b1;
			default: ;
		endcase
		if (!valid) begin
			{rs_used, rt_used, wr, ld, br, jalr} = '0;
		end
	endtask

	function automatic fwd_sel_t nearest_source(input logic used, input logic [NUM_STAGES-1:0] hit);
		if (!used) return FWD_NONE;
		if (hit[0]) return FWD_EX;
		if (hit[1]) return FWD_MEM;
		if (hit[2]) return FWD_WB;
		return FWD_NONE;
	endfunction

	// Expected outputs for the current word against the model slots
	task automatic verify_cycle();
		reg_idx_t              rs;
		reg_idx_t              rt;
		logic                  rs_used;
		logic                  rt_used;
		logic                  br;
		logic                  jalr;
		logic [NUM_STAGES-1:0] rs_hit;
		logic [NUM_STAGES-1:0] rt_hit;
		logic                  exp_xd;
		fwd_sel_t              exp_rs;
		fwd_sel_t              exp_rt;
		decode_word(instr, instr_valid, rs, rt, cur_dest, rs_used, rt_used, cur_wr, cur_ld,
			br, jalr);
		for (int k = 0; k < NUM_STAGES; k++) begin
			rs_hit[k] = slot_wr[k] && (slot_dest[k] == rs);
			rt_hit[k] = slot_wr[k] && (slot_dest[k] == rt);
		end
		exp_stall = slot_ld[0] && ((rs_used && rs_hit[0]) || (rt_used && rt_hit[0]));
		exp_xd = 1'b0;
		if (br && rs_used) begin
			if (rs_hit[0]) begin
				if (!(jalr && !slot_ld[0])) exp_stall = 1'b1;	// JALR may take an ALU result
			end else if (rs_hit[1]) begin
				if (slot_ld[1]) exp_stall = 1'b1;
				else exp_xd = 1'b1;
			end
		end
		exp_rs = exp_stall ? FWD_NONE : nearest_source(rs_used, rs_hit);
		exp_rt = exp_stall ? FWD_NONE : nearest_source(rt_used, rt_hit);
		check_level("stall", stall, exp_stall);
		check_level("xd_fwd", xd_fwd, exp_xd);
		check_sel("fwd_rs_sel", fwd_rs_sel, exp_rs);
		check_sel("fwd_rt_sel", fwd_rt_sel, exp_rt);
		if (hazard_unit_top_i.hazard_unit_chk_i.fail_count != 0) begin
			report_failure("a bound assertion on the hazard unit failed");
		end
	endtask

	// Model clock edge, a bubble enters EX on a stall
	task automatic advance_model();
		for (int k = NUM_STAGES - 1; k > 0; k--) begin
			slot_dest[k] = slot_dest[k-1];
			slot_wr[k] = slot_wr[k-1];
			slot_ld[k] = slot_ld[k-1];
		end
		slot_dest[0] = cur_dest;
		slot_wr[0] = cur_wr && !exp_stall;
		slot_ld[0] = cur_ld && !exp_stall;
	endtask

	// Entered 1 unit after a rising edge, leaves at the same point
	task automatic apply_entry(input int idx);
		int held;
		held = 0;
		instr = tab_word[idx];
		instr_valid = tab_valid[idx];
		#4;
		verify_cycle();
		while (stall) begin
			if (held == 4) begin
				report_failure($sformatf("entry %0d still stalled after 4 cycles", idx));
			end
			advance_model();
			@(posedge clk);
			#5;
			held++;
			verify_cycle();
		end
		expect_stalls($sformatf("entry %0d", idx), held, tab_stalls[idx]);
		check_sel($sformatf("entry %0d rs select", idx), fwd_rs_sel, tab_rs[idx]);
		check_sel($sformatf("entry %0d rt select", idx), fwd_rt_sel, tab_rt[idx]);
		check_level($sformatf("entry %0d xd_fwd", idx), xd_fwd, tab_xd[idx]);
		advance_model();
		@(posedge clk);
		#1;
	endtask

	task automatic build_table();
		// ALU producer read at distances 1 to 4; ADDI is 01000
		add_entry(three_reg(OP_ALU_R, 3'd1, 3'd2, 3'd3), 1'b1, 0, FWD_NONE, FWD_NONE, 1'b0);
		add_entry(three_reg(OP_ALU_R, 3'd3, 3'd4, 3'd5), 1'b1, 0, FWD_EX, FWD_NONE, 1'b0);
		add_entry(three_reg(OP_ALU_R, 3'd6, 3'd3, 3'd6), 1'b1, 0, FWD_NONE, FWD_MEM, 1'b0);
		add_entry(three_reg(OP_ALU_R, 3'd3, 3'd0, 3'd1), 1'b1, 0, FWD_WB, FWD_NONE, 1'b0);
		add_entry(reg_imm5(5'b01000, 3'd3, 3'd1, 5'd0), 1'b1, 0, FWD_NONE, FWD_NONE, 1'b0);
		// Load-use on ALU and store data, then an independent reader
		add_entry(reg_imm5(OP_LD, 3'd2, 3'd4, 5'd0), 1'b1, 0, FWD_NONE, FWD_NONE, 1'b0);
		add_entry(three_reg(OP_ALU_R, 3'd4, 3'd1, 3'd5), 1'b1, 1, FWD_MEM, FWD_WB, 1'b0);
		add_entry(reg_imm5(OP_LD, 3'd0, 3'd6, 5'd0), 1'b1, 0, FWD_NONE, FWD_NONE, 1'b0);
		add_entry(reg_imm5(OP_ST, 3'd1, 3'd6, 5'd0), 1'b1, 1, FWD_NONE, FWD_MEM, 1'b0);
		add_entry(reg_imm5(OP_LD, 3'd5, 3'd2, 5'd0), 1'b1, 0, FWD_NONE, FWD_NONE, 1'b0);
		add_entry(three_reg(OP_ALU_R, 3'd3, 3'd0, 3'd7), 1'b1, 0, FWD_NONE, FWD_NONE, 1'b0);
		// BEQZ after ALU, then after a load
		add_entry(reg_imm8({BRANCH_PREFIX, 2'b00}, 3'd7, 8'd0), 1'b1, 1, FWD_MEM, FWD_NONE, 1'b1);
		add_entry(reg_imm5(OP_LD, 3'd0, 3'd3, 5'd0), 1'b1, 0, FWD_NONE, FWD_NONE, 1'b0);
		add_entry(reg_imm8({BRANCH_PREFIX, 2'b00}, 3'd3, 8'd0), 1'b1, 2, FWD_WB, FWD_NONE, 1'b0);
		// JALR passes an ALU result, JR does not
		add_entry(reg_imm5(5'b01000, 3'd0, 3'd2, 5'd5), 1'b1, 0, FWD_NONE, FWD_NONE, 1'b0);
		add_entry(reg_imm8(OP_JALR, 3'd2, 8'd0), 1'b1, 0, FWD_EX, FWD_NONE, 1'b0);
		add_entry(reg_imm8(OP_JR, 3'd7, 8'd0), 1'b1, 1, FWD_MEM, FWD_NONE, 1'b1);
		// Unused fields: LBI, J, NOP, invalid words
		add_entry(reg_imm8(OP_LBI, 3'd7, 8'hff), 1'b1, 0, FWD_NONE, FWD_NONE, 1'b0);
		add_entry(reg_imm8(OP_J, 3'd7, 8'd0), 1'b1, 0, FWD_NONE, FWD_NONE, 1'b0);
		add_entry(reg_imm8(OP_NOP, 3'd7, 8'd0), 1'b1, 0, FWD_NONE, FWD_NONE, 1'b0);
		add_entry(three_reg(OP_ALU_R, 3'd7, 3'd7, 3'd7), 1'b0, 0, FWD_NONE, FWD_NONE, 1'b0);
		add_entry(reg_imm5(OP_LD, 3'd0, 3'd4, 5'd0), 1'b0, 0, FWD_NONE, FWD_NONE, 1'b0);
		add_entry(three_reg(OP_ALU_R, 3'd4, 3'd4, 3'd1), 1'b1, 0, FWD_NONE, FWD_NONE, 1'b0);
		// Store and branch as producers write nothing
		add_entry(reg_imm5(OP_ST, 3'd1, 3'd2, 5'd0), 1'b1, 0, FWD_EX, FWD_NONE, 1'b0);
		add_entry(three_reg(OP_ALU_R, 3'd2, 3'd2, 3'd3), 1'b1, 0, FWD_NONE, FWD_NONE, 1'b0);
		add_entry(reg_imm8({BRANCH_PREFIX, 2'b00}, 3'd1, 8'he0), 1'b1, 0, FWD_WB, FWD_NONE, 1'b0);
		add_entry(three_reg(OP_ALU_R, 3'd7, 3'd5, 3'd4), 1'b1, 0, FWD_NONE, FWD_NONE, 1'b0);
		// SEQ and a shift read both operands
		add_entry(three_reg({SET_PREFIX, 2'b00}, 3'd4, 3'd4, 3'd6), 1'b1, 0, FWD_EX, FWD_EX, 1'b0);
		add_entry(three_reg(OP_SHIFT_R, 3'd6, 3'd3, 3'd0), 1'b1, 0, FWD_EX, FWD_NONE, 1'b0);
	endtask

	initial begin
		arst_n = 1'b0;
		instr = reg_imm8(OP_NOP, 3'd0, 8'd0);
		instr_valid = 1'b0;
		for (int k = 0; k < NUM_STAGES; k++) begin
			slot_dest[k] = '0;
			slot_wr[k] = 1'b0;
			slot_ld[k] = 1'b0;
		end
		build_table();
		repeat (3) @(posedge clk);
		#1;
		arst_n = 1'b1;
		for (int i = 0; i < tab_word.size(); i++) begin
			apply_entry(i);
		end
		if (hazard_unit_top_i.hazard_unit_chk_i.fail_count != 0) begin
			report_failure("a bound assertion on the hazard unit failed");
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

//--- compile.f
verilog/hazard_pkg.sv
verilog/instr_decode.sv
verilog/dest_slot.sv
verilog/hazard_detection.sv
verilog/hazard_unit_top.sv
sim/hazard_unit_chk.sv
sim/hazard_unit_tb.sv
